// File: source/mshr_pkg.sv
`default_nettype none

package mshr_pkg;

  // memory transaction tag, 0 means no transaction
  localparam int tag_width = 4;

  // memory bus command
  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_command_t;

  // life of a table entry
  typedef enum logic [1:0] {
    WAITING    = 2'd0,
    INPROGRESS = 2'd1,
    DONE       = 2'd2
  } entry_state_t;

  // what the cache hands over
  typedef enum logic {
    MISS_LOAD  = 1'b0,
    MISS_EVICT = 1'b1
  } miss_kind_t;

endpackage

`default_nettype wire

// File: source/miss_intake.sv
`timescale 1ns/1ps
`default_nettype none

module miss_intake import mshr_pkg::*; #(
  parameter int addr_width = 32,
  parameter int data_width = 64
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   miss_req,
  input  wire miss_kind_t       miss_kind,
  input  wire  [addr_width-1:0] miss_addr,
  input  wire  [data_width-1:0] miss_data,
  input  wire                   full,
  input  wire                   lookup_hit_load,
  input  wire                   lookup_hit_evict,
  input  wire  [data_width-1:0] lookup_data,
  output logic                  miss_ack,
  output logic                  fwd_valid,
  output logic [data_width-1:0] fwd_data,
  output logic                  alloc,
  output miss_kind_t            alloc_kind,
  output logic [addr_width-1:0] alloc_addr,
  output logic [data_width-1:0] alloc_data
);

  logic is_load;
  logic merge;
  logic forward;
  logic can_settle;

  // forwarding wins over merging, the eviction data is the newest copy
  assign is_load    = (miss_kind == MISS_LOAD);
  assign forward    = is_load && lookup_hit_evict;
  assign merge      = is_load && lookup_hit_load && !lookup_hit_evict;
  assign can_settle = merge || forward || !full;

  // miss_ack doubles as the handshake phase
  always_ff @(posedge clock) begin
    if (reset) begin
      miss_ack  <= 1'b0;
      fwd_valid <= 1'b0;
      alloc     <= 1'b0;
    end else begin
      alloc <= 1'b0;
      if (!miss_ack && miss_req && can_settle) begin
        miss_ack  <= 1'b1;
        fwd_valid <= forward;
        alloc     <= !merge && !forward;
      end else if (miss_ack && !miss_req) begin
        miss_ack  <= 1'b0;
        fwd_valid <= 1'b0;
      end
    end
  end

  // capture while idle, held through the ack phase
  always_ff @(posedge clock) begin
    if (!miss_ack && miss_req) begin
      alloc_kind <= miss_kind;
      alloc_addr <= miss_addr;
      alloc_data <= miss_data;
      fwd_data   <= lookup_data;
    end
  end

  // full was low when the miss was taken, and nothing else allocates in between
  a_no_alloc_when_full: assert property (
    @(posedge clock) disable iff (reset) alloc |-> !full
  ) else $error("allocation into a full table");

endmodule

`default_nettype wire

// File: source/mshr_table.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_table import mshr_pkg::*; #(
  parameter int depth      = 8,
  parameter int addr_width = 32,
  parameter int data_width = 64
) (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        alloc,
  input  wire miss_kind_t            alloc_kind,
  input  wire  [addr_width-1:0]      alloc_addr,
  input  wire  [data_width-1:0]      alloc_data,
  input  wire  [addr_width-1:0]      miss_addr,
  input  wire  [$clog2(depth)-1:0]   head_index,
  input  wire                        issue_accept,
  input  wire  [tag_width-1:0]       issue_tag,
  input  wire  [tag_width-1:0]       mem_tag,
  input  wire  [data_width-1:0]      mem_rdata,
  input  wire  [$clog2(depth)-1:0]   wb_index,
  input  wire                        wb_release,
  output logic                       full,
  output logic                       lookup_hit_load,
  output logic                       lookup_hit_evict,
  output logic [data_width-1:0]      lookup_data,
  output logic                       head_valid,
  output entry_state_t               head_state,
  output miss_kind_t                 head_kind,
  output logic [addr_width-1:0]      head_addr,
  output logic [data_width-1:0]      head_data,
  output logic                       wb_valid,
  output entry_state_t               wb_state,
  output miss_kind_t                 wb_kind,
  output logic [addr_width-1:0]      wb_addr,
  output logic [data_width-1:0]      wb_data
);

  localparam int index_width = $clog2(depth);

  logic                   entry_valid [depth];
  entry_state_t           entry_state [depth];
  miss_kind_t             entry_kind  [depth];
  logic [tag_width-1:0]   entry_tag   [depth];
  logic [addr_width-1:0]  entry_addr  [depth];
  logic [data_width-1:0]  entry_data  [depth];

  logic [index_width-1:0] tail;
  logic [depth-1:0]       complete_hit;
  logic                   tag_clash;

  assign full = entry_valid[tail];

  assign head_valid = entry_valid[head_index];
  assign head_state = entry_state[head_index];
  assign head_kind  = entry_kind[head_index];
  assign head_addr  = entry_addr[head_index];
  assign head_data  = entry_data[head_index];

  assign wb_valid = entry_valid[wb_index];
  assign wb_state = entry_state[wb_index];
  assign wb_kind  = entry_kind[wb_index];
  assign wb_addr  = entry_addr[wb_index];
  assign wb_data  = entry_data[wb_index];

  // scan from the oldest entry so the newest eviction supplies the data
  always_comb begin
    logic [index_width-1:0] scan;
    lookup_hit_load  = 1'b0;
    lookup_hit_evict = 1'b0;
    lookup_data      = '0;
    for (int i = 0; i < depth; i++) begin
      scan = wb_index + index_width'(i);
      if (entry_valid[scan] && entry_addr[scan] == miss_addr) begin
        if (entry_kind[scan] == MISS_LOAD) begin
          lookup_hit_load = 1'b1;
        end else begin
          lookup_hit_evict = 1'b1;
          lookup_data      = entry_data[scan];
        end
      end
    end
  end

  // tag match against loads in flight
  always_comb begin
    for (int i = 0; i < depth; i++) begin
      complete_hit[i] = entry_valid[i] && entry_state[i] == INPROGRESS &&
                        entry_kind[i] == MISS_LOAD && mem_tag != '0 &&
                        entry_tag[i] == mem_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
      for (int i = 0; i < depth; i++) begin
        entry_valid[i] <= 1'b0;
        entry_state[i] <= WAITING;
      end
    end else begin
      for (int i = 0; i < depth; i++) begin
        if (complete_hit[i]) begin
          entry_state[i] <= DONE;
        end
      end
      // evictions need no response data
      if (issue_accept) begin
        entry_state[head_index] <= (entry_kind[head_index] == MISS_EVICT) ? DONE : INPROGRESS;
      end
      if (alloc) begin
        entry_valid[tail] <= 1'b1;
        entry_state[tail] <= WAITING;
        tail              <= tail + 1'b1;
      end
      if (wb_release) begin
        entry_valid[wb_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < depth; i++) begin
      if (complete_hit[i]) begin
        entry_data[i] <= mem_rdata;
      end
    end
    if (issue_accept) begin
      entry_tag[head_index] <= issue_tag;
    end
    if (alloc) begin
      entry_kind[tail] <= alloc_kind;
      entry_addr[tail] <= alloc_addr;
      entry_data[tail] <= alloc_data;
    end
  end

  always_comb begin
    tag_clash = 1'b0;
    for (int i = 0; i < depth; i++) begin
      for (int j = i + 1; j < depth; j++) begin
        if (entry_valid[i] && entry_valid[j] && entry_state[i] == INPROGRESS &&
            entry_state[j] == INPROGRESS && entry_tag[i] == entry_tag[j]) begin
          tag_clash = 1'b1;
        end
      end
    end
  end

  a_release_done: assert property (
    @(posedge clock) disable iff (reset) wb_release |-> wb_valid && wb_state == DONE
  ) else $error("release of an entry that is not done");

  a_unique_tags: assert property (
    @(posedge clock) disable iff (reset) !tag_clash
  ) else $error("two loads in flight share a memory tag");

endmodule

`default_nettype wire

// File: source/mem_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mem_issue import mshr_pkg::*; #(
  parameter int depth      = 8,
  parameter int addr_width = 32,
  parameter int data_width = 64
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       head_valid,
  input  wire entry_state_t         head_state,
  input  wire miss_kind_t           head_kind,
  input  wire  [addr_width-1:0]     head_addr,
  input  wire  [data_width-1:0]     head_data,
  input  wire  [tag_width-1:0]      mem_response,
  output logic [$clog2(depth)-1:0]  head_index,
  output logic                      issue_accept,
  output logic [tag_width-1:0]      issue_tag,
  output bus_command_t              mem_command,
  output logic [addr_width-1:0]     mem_addr,
  output logic [data_width-1:0]     mem_wdata
);

  logic head_pending;

  assign head_pending = head_valid && head_state == WAITING;

  always_comb begin
    if (!head_pending) begin
      mem_command = BUS_NONE;
    end else if (head_kind == MISS_LOAD) begin
      mem_command = BUS_LOAD;
    end else begin
      mem_command = BUS_STORE;
    end
  end

  assign mem_addr  = head_addr;
  assign mem_wdata = head_data;

  // a nonzero response is both the acceptance and the tag to match later
  assign issue_accept = head_pending && mem_response != '0;
  assign issue_tag    = mem_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_index <= '0;
    end else if (issue_accept) begin
      head_index <= head_index + 1'b1;
    end
  end

  // the head entry must not move or change under a pending request
  a_request_stable: assert property (
    @(posedge clock) disable iff (reset)
    (mem_command != BUS_NONE && mem_response == '0) |=>
      $stable(mem_command) && $stable(mem_addr) && $stable(mem_wdata)
  ) else $error("memory request changed before acceptance");

endmodule

`default_nettype wire

// File: source/refill_retire.sv
`timescale 1ns/1ps
`default_nettype none

module refill_retire import mshr_pkg::*; #(
  parameter int depth      = 8,
  parameter int addr_width = 32,
  parameter int data_width = 64
) (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       wb_valid,
  input  wire entry_state_t         wb_state,
  input  wire miss_kind_t           wb_kind,
  input  wire  [addr_width-1:0]     wb_addr,
  input  wire  [data_width-1:0]     wb_data,
  input  wire                       refill_ack,
  output logic [$clog2(depth)-1:0]  wb_index,
  output logic                      wb_release,
  output logic                      refill_valid,
  output logic [addr_width-1:0]     refill_addr,
  output logic [data_width-1:0]     refill_data
);

  logic head_done;
  logic load_ready;
  logic evict_ready;

  assign head_done   = wb_valid && wb_state == DONE;
  assign load_ready  = head_done && wb_kind == MISS_LOAD;
  assign evict_ready = head_done && wb_kind == MISS_EVICT;

  // a finished eviction leaves without bothering the cache
  assign wb_release = refill_valid ? refill_ack : evict_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_index     <= '0;
      refill_valid <= 1'b0;
    end else begin
      if (wb_release) begin
        wb_index <= wb_index + 1'b1;
      end
      // wait for ack to fall before the next refill
      if (refill_valid && refill_ack) begin
        refill_valid <= 1'b0;
      end else if (!refill_valid && !refill_ack && load_ready) begin
        refill_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!refill_valid) begin
      refill_addr <= wb_addr;
      refill_data <= wb_data;
    end
  end

  a_refill_stable: assert property (
    @(posedge clock) disable iff (reset)
    (refill_valid && !refill_ack) |=> refill_valid && $stable(refill_addr)
  ) else $error("refill dropped or changed before ack");

endmodule

`default_nettype wire

// File: source/mshr_top.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_top import mshr_pkg::*; #(
  parameter int depth      = 8,
  parameter int addr_width = 32,
  parameter int data_width = 64
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   miss_req,
  input  wire miss_kind_t       miss_kind,
  input  wire  [addr_width-1:0] miss_addr,
  input  wire  [data_width-1:0] miss_data,
  output logic                  miss_ack,
  output logic                  fwd_valid,
  output logic [data_width-1:0] fwd_data,
  output logic                  refill_valid,
  output logic [addr_width-1:0] refill_addr,
  output logic [data_width-1:0] refill_data,
  input  wire                   refill_ack,
  output bus_command_t          mem_command,
  output logic [addr_width-1:0] mem_addr,
  output logic [data_width-1:0] mem_wdata,
  input  wire  [tag_width-1:0]  mem_response,
  input  wire  [tag_width-1:0]  mem_tag,
  input  wire  [data_width-1:0] mem_rdata
);

  localparam int index_width = $clog2(depth);

  logic                   alloc;
  miss_kind_t             alloc_kind;
  logic [addr_width-1:0]  alloc_addr;
  logic [data_width-1:0]  alloc_data;
  logic                   full;
  logic                   lookup_hit_load;
  logic                   lookup_hit_evict;
  logic [data_width-1:0]  lookup_data;

  logic [index_width-1:0] head_index;
  logic                   head_valid;
  entry_state_t           head_state;
  miss_kind_t             head_kind;
  logic [addr_width-1:0]  head_addr;
  logic [data_width-1:0]  head_data;
  logic                   issue_accept;
  logic [tag_width-1:0]   issue_tag;

  logic [index_width-1:0] wb_index;
  logic                   wb_release;
  logic                   wb_valid;
  entry_state_t           wb_state;
  miss_kind_t             wb_kind;
  logic [addr_width-1:0]  wb_addr;
  logic [data_width-1:0]  wb_data;

  miss_intake #(
    .addr_width(addr_width),
    .data_width(data_width)
  ) intake0 (
    .clock(clock), .reset(reset),
    .miss_req(miss_req), .miss_kind(miss_kind), .miss_addr(miss_addr), .miss_data(miss_data),
    .full(full), .lookup_hit_load(lookup_hit_load), .lookup_hit_evict(lookup_hit_evict),
    .lookup_data(lookup_data),
    .miss_ack(miss_ack), .fwd_valid(fwd_valid), .fwd_data(fwd_data),
    .alloc(alloc), .alloc_kind(alloc_kind), .alloc_addr(alloc_addr), .alloc_data(alloc_data)
  );

  mshr_table #(
    .depth(depth),
    .addr_width(addr_width),
    .data_width(data_width)
  ) table0 (
    .clock(clock), .reset(reset),
    .alloc(alloc), .alloc_kind(alloc_kind), .alloc_addr(alloc_addr), .alloc_data(alloc_data),
    .miss_addr(miss_addr), .head_index(head_index),
    .issue_accept(issue_accept), .issue_tag(issue_tag),
    .mem_tag(mem_tag), .mem_rdata(mem_rdata),
    .wb_index(wb_index), .wb_release(wb_release),
    .full(full), .lookup_hit_load(lookup_hit_load), .lookup_hit_evict(lookup_hit_evict),
    .lookup_data(lookup_data),
    .head_valid(head_valid), .head_state(head_state), .head_kind(head_kind),
    .head_addr(head_addr), .head_data(head_data),
    .wb_valid(wb_valid), .wb_state(wb_state), .wb_kind(wb_kind),
    .wb_addr(wb_addr), .wb_data(wb_data)
  );

  mem_issue #(
    .depth(depth),
    .addr_width(addr_width),
    .data_width(data_width)
  ) issue0 (
    .clock(clock), .reset(reset),
    .head_valid(head_valid), .head_state(head_state), .head_kind(head_kind),
    .head_addr(head_addr), .head_data(head_data), .mem_response(mem_response),
    .head_index(head_index), .issue_accept(issue_accept), .issue_tag(issue_tag),
    .mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  refill_retire #(
    .depth(depth),
    .addr_width(addr_width),
    .data_width(data_width)
  ) retire0 (
    .clock(clock), .reset(reset),
    .wb_valid(wb_valid), .wb_state(wb_state), .wb_kind(wb_kind),
    .wb_addr(wb_addr), .wb_data(wb_data), .refill_ack(refill_ack),
    .wb_index(wb_index), .wb_release(wb_release),
    .refill_valid(refill_valid), .refill_addr(refill_addr), .refill_data(refill_data)
  );

endmodule

`default_nettype wire

// File: test/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import mshr_pkg::*; #(
  parameter int addr_width = 32,
  parameter int data_width = 64
) (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   hold,
  input  wire bus_command_t     mem_command,
  input  wire  [addr_width-1:0] mem_addr,
  input  wire  [data_width-1:0] mem_wdata,
  input  wire  [addr_width-1:0] watch_addr,
  output logic [tag_width-1:0]  mem_response,
  output logic [tag_width-1:0]  mem_tag,
  output logic [data_width-1:0] mem_rdata,
  output int                    watch_loads
);

  logic [data_width-1:0] lines [logic [addr_width-1:0]];
  logic [tag_width-1:0]  pend_tag [$];
  logic [addr_width-1:0] pend_addr [$];
  logic                  tag_busy [1 << tag_width];
  logic [tag_width-1:0]  next_tag;
  int                    stall;

  // lines never stored read as the inverted address
  function automatic logic [data_width-1:0] read_line(input logic [addr_width-1:0] addr);
    if (lines.exists(addr)) begin
      return lines[addr];
    end
    return ~data_width'(addr);
  endfunction

  initial begin
    mem_response = '0;
    mem_tag      = '0;
    mem_rdata    = '0;
    watch_loads  = 0;
    next_tag     = 1;
    stall        = 0;
    for (int i = 0; i < (1 << tag_width); i++) begin
      tag_busy[i] = 1'b0;
    end
  end

  always @(negedge clock) begin
    int pick;
    mem_tag   = '0;
    mem_rdata = '0;
    if (reset) begin
      mem_response = '0;
      stall        = 0;
    end else begin
      // finish any earlier load, in random order
      if (pend_tag.size() > 0 && $urandom_range(1, 0) == 1) begin
        pick      = $urandom_range(pend_tag.size() - 1, 0);
        mem_tag   = pend_tag[pick];
        mem_rdata = read_line(pend_addr[pick]);
        tag_busy[pend_tag[pick]] = 1'b0;
        pend_tag.delete(pick);
        pend_addr.delete(pick);
      end
      if (mem_response != '0) begin
        // taken at the last edge
        mem_response = '0;
        stall        = $urandom_range(3, 0);
      end else if (mem_command != BUS_NONE && !hold) begin
        if (stall > 0) begin
          stall--;
        end else begin
          while (next_tag == '0 || tag_busy[next_tag]) begin
            next_tag++;
          end
          mem_response = next_tag;
          if (mem_command == BUS_LOAD) begin
            tag_busy[next_tag] = 1'b1;
            pend_tag.push_back(next_tag);
            pend_addr.push_back(mem_addr);
            if (mem_addr == watch_addr) begin
              watch_loads++;
            end
          end else begin
            lines[mem_addr] = mem_wdata;
          end
          next_tag++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/mshr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mshr_tb import mshr_pkg::*; ();

  localparam int depth          = 8;
  localparam int addr_width     = 32;
  localparam int data_width     = 64;
  // all tests together need well under a thousand cycles
  localparam int timeout_cycles = 4000;
  localparam int settle_cycles  = 30;

  logic                  clock;
  logic                  reset;
  logic                  miss_req;
  miss_kind_t            miss_kind;
  logic [addr_width-1:0] miss_addr;
  logic [data_width-1:0] miss_data;
  logic                  miss_ack;
  logic                  fwd_valid;
  logic [data_width-1:0] fwd_data;
  logic                  refill_valid;
  logic [addr_width-1:0] refill_addr;
  logic [data_width-1:0] refill_data;
  logic                  refill_ack;
  bus_command_t          mem_command;
  logic [addr_width-1:0] mem_addr;
  logic [data_width-1:0] mem_wdata;
  logic [tag_width-1:0]  mem_response;
  logic [tag_width-1:0]  mem_tag;
  logic [data_width-1:0] mem_rdata;
  logic                  hold;
  logic [addr_width-1:0] watch_addr;
  int                    watch_loads;

  int                    errors = 0;
  int                    cycles = 0;
  logic [data_width-1:0] stored_lines [logic [addr_width-1:0]];
  logic [addr_width-1:0] got_addr [$];
  logic [data_width-1:0] got_data [$];
  logic [addr_width-1:0] exp_addr [$];
  logic [data_width-1:0] exp_data [$];

  mshr_top #(
    .depth(depth),
    .addr_width(addr_width),
    .data_width(data_width)
  ) dut0 (
    .clock(clock), .reset(reset),
    .miss_req(miss_req), .miss_kind(miss_kind), .miss_addr(miss_addr), .miss_data(miss_data),
    .miss_ack(miss_ack), .fwd_valid(fwd_valid), .fwd_data(fwd_data),
    .refill_valid(refill_valid), .refill_addr(refill_addr), .refill_data(refill_data),
    .refill_ack(refill_ack),
    .mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_response(mem_response), .mem_tag(mem_tag), .mem_rdata(mem_rdata)
  );

  mem_model #(
    .addr_width(addr_width),
    .data_width(data_width)
  ) mem0 (
    .clock(clock), .reset(reset), .hold(hold),
    .mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .watch_addr(watch_addr), .mem_response(mem_response), .mem_tag(mem_tag),
    .mem_rdata(mem_rdata), .watch_loads(watch_loads)
  );

  initial begin
    clock = 1'b0;
  end

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("summary: %0d errors", errors);
      $display("Verification failed");
      $finish;
    end
  end

  // cache refill side acks at once
  always @(negedge clock) begin
    if (reset) begin
      refill_ack = 1'b0;
    end else if (refill_valid && !refill_ack) begin
      got_addr.push_back(refill_addr);
      got_data.push_back(refill_data);
      refill_ack = 1'b1;
    end else if (!refill_valid && refill_ack) begin
      refill_ack = 1'b0;
    end
  end

  function automatic logic [data_width-1:0] memory_line(input logic [addr_width-1:0] addr);
    if (stored_lines.exists(addr)) begin
      return stored_lines[addr];
    end
    return ~data_width'(addr);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic raise_miss(input miss_kind_t kind, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data);
    miss_req  = 1'b1;
    miss_kind = kind;
    miss_addr = addr;
    miss_data = data;
    if (kind == MISS_EVICT) begin
      stored_lines[addr] = data;
    end
  endtask

  task automatic finish_miss(output logic fwd, output logic [data_width-1:0] fwd_d,
                             output int waited);
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!miss_ack);
    fwd      = fwd_valid;
    fwd_d    = fwd_data;
    miss_req = 1'b0;
    do begin
      @(negedge clock);
    end while (miss_ack);
  endtask

  task automatic send_miss(input miss_kind_t kind, input logic [addr_width-1:0] addr,
                           input logic [data_width-1:0] data, output logic fwd,
                           output logic [data_width-1:0] fwd_d, output int waited);
    raise_miss(kind, addr, data);
    finish_miss(fwd, fwd_d, waited);
  endtask

  task automatic expect_load(input logic [addr_width-1:0] addr);
    exp_addr.push_back(addr);
    exp_data.push_back(memory_line(addr));
  endtask

  task automatic clear_records();
    exp_addr.delete();
    exp_data.delete();
    got_addr.delete();
    got_data.delete();
  endtask

  task automatic settle();
    repeat (settle_cycles) @(negedge clock);
  endtask

  task automatic compare_refills(input string name);
    while (got_addr.size() < exp_addr.size()) begin
      @(negedge clock);
    end
    settle();
    check_value({name, " refill count"}, exp_addr.size(), got_addr.size());
    for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
      check_value({name, " refill addr"}, exp_addr[i], got_addr[i]);
      check_value({name, " refill data"}, exp_data[i], got_data[i]);
    end
  endtask

  initial begin
    logic                  fwd;
    logic [data_width-1:0] fwd_d;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    int                    waited;
    int                    loads_before;
    void'($urandom(32'ha21e));
    reset      = 1'b1;
    miss_req   = 1'b0;
    miss_kind  = MISS_LOAD;
    miss_addr  = '0;
    miss_data  = '0;
    refill_ack = 1'b0;
    hold       = 1'b0;
    watch_addr = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    check_value("reset miss_ack", 0, miss_ack);
    check_value("reset fwd_valid", 0, fwd_valid);
    check_value("reset refill_valid", 0, refill_valid);
    check_value("reset mem_command", BUS_NONE, mem_command);

    // single load
    clear_records();
    send_miss(MISS_LOAD, 32'h0000_1000, '0, fwd, fwd_d, waited);
    check_value("single_load ack latency", 1, waited);
    check_value("single_load fwd_valid", 0, fwd);
    expect_load(32'h0000_1000);
    compare_refills("single_load");

    // second load to a pending line merges
    clear_records();
    watch_addr   = 32'h0000_2040;
    hold         = 1'b1;
    loads_before = watch_loads;
    send_miss(MISS_LOAD, 32'h0000_2040, '0, fwd, fwd_d, waited);
    expect_load(32'h0000_2040);
    send_miss(MISS_LOAD, 32'h0000_2040, '0, fwd, fwd_d, waited);
    check_value("merge fwd_valid", 0, fwd);
    hold = 1'b0;
    compare_refills("merge");
    check_value("merge bus loads", 1, watch_loads - loads_before);

    // load against a pending eviction
    clear_records();
    watch_addr   = 32'h0000_3080;
    data         = {$urandom, $urandom};
    hold         = 1'b1;
    loads_before = watch_loads;
    send_miss(MISS_EVICT, 32'h0000_3080, data, fwd, fwd_d, waited);
    send_miss(MISS_LOAD, 32'h0000_3080, '0, fwd, fwd_d, waited);
    check_value("forward fwd_valid", 1, fwd);
    check_value("forward fwd_data", data, fwd_d);
    hold = 1'b0;
    settle();
    check_value("forward bus loads", 0, watch_loads - loads_before);
    check_value("forward refill count", 0, got_addr.size());
    send_miss(MISS_LOAD, 32'h0000_3080, '0, fwd, fwd_d, waited);
    check_value("forward later fwd_valid", 0, fwd);
    exp_addr.push_back(32'h0000_3080);
    exp_data.push_back(data);
    compare_refills("forward later");

    // stalls and out of order tags with one eviction in the mix
    clear_records();
    for (int i = 0; i < 7; i++) begin
      addr = 32'h0010_0000 + i * 32'h40 + ($urandom & 32'h3c);
      if (i == 3) begin
        send_miss(MISS_EVICT, addr, {$urandom, $urandom}, fwd, fwd_d, waited);
      end else begin
        send_miss(MISS_LOAD, addr, '0, fwd, fwd_d, waited);
        expect_load(addr);
      end
    end
    compare_refills("out_of_order");

    // fill the table with memory held off
    clear_records();
    hold = 1'b1;
    for (int i = 0; i < depth; i++) begin
      addr = 32'h0020_0000 + i * 32'h40;
      send_miss(MISS_LOAD, addr, '0, fwd, fwd_d, waited);
      expect_load(addr);
    end
    raise_miss(MISS_LOAD, 32'h0020_1000, '0);
    repeat (10) begin
      @(negedge clock);
      check_value("full miss_ack", 0, miss_ack);
    end
    hold = 1'b0;
    finish_miss(fwd, fwd_d, waited);
    expect_load(32'h0020_1000);
    compare_refills("full");

    $display("summary: %0d errors", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
source/mshr_pkg.sv
source/miss_intake.sv
source/mshr_table.sv
source/mem_issue.sv
source/refill_retire.sv
source/mshr_top.sv
test/mem_model.sv
test/mshr_tb.sv
